//--- mips_alu.sv
`timescale 1ns/10ps

module mips_alu (
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  logic [4:0]        shamt,
    input  mips_pkg::alu_op_t op,
    output logic [31:0]       result,
    output logic              zero
);
    import mips_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            ALU_SLTU: begin
                result = {31'b0, a < b};
            end
            // shifts act on the rt operand by the instruction's shamt
            ALU_SLL: result = b << shamt;
            ALU_SRL: result = b >> shamt;
            ALU_LUI: result = {b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // used for beq and bne after a subtract
    assign zero = (result == '0);

endmodule

//--- mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// address of the very first instruction fetch
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// a jr to this address stops the core
`define MIPS_HALT_ADDR 32'h0000_0000

// general purpose register file geometry
`define MIPS_NREGS 32
`define MIPS_REG_AW 5

`endif

//--- mips_control.sv
`timescale 1ns/10ps

module mips_control (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             waitrequest,
    input  mips_pkg::instr_t ir,
    input  logic             zero,
    input  logic             halt,
    output mips_pkg::ctrl_t  ctrl,
    output logic             active
);
    import mips_pkg::*;

    state_t  state;
    state_t  state_next;
    opcode_t op;
    funct_t  fn;
    alu_op_t r_alu_op;
    alu_op_t i_alu_op;
    logic    started;
    logic    is_rtype;
    logic    is_jr;
    logic    is_load;
    logic    is_store;
    logic    is_branch;
    logic    is_jump;
    logic    is_ialu;

    assign op        = ir.i.opcode;
    assign fn        = ir.r.funct;
    assign is_rtype  = (op == OP_SPECIAL);
    assign is_jr     = is_rtype && (fn == F_JR);
    assign is_load   = (op == OP_LW);
    assign is_store  = (op == OP_SW);
    assign is_branch = (op == OP_BEQ) || (op == OP_BNE);
    assign is_jump   = (op == OP_J);
    assign is_ialu   = (op == OP_ADDIU) || (op == OP_SLTI) || (op == OP_ANDI) ||
                       (op == OP_ORI) || (op == OP_XORI) || (op == OP_LUI);

    always_comb begin
        case (fn)
            F_SUBU:  r_alu_op = ALU_SUB;
            F_AND:   r_alu_op = ALU_AND;
            F_OR:    r_alu_op = ALU_OR;
            F_XOR:   r_alu_op = ALU_XOR;
            F_SLT:   r_alu_op = ALU_SLT;
            F_SLTU:  r_alu_op = ALU_SLTU;
            F_SLL:   r_alu_op = ALU_SLL;
            F_SRL:   r_alu_op = ALU_SRL;
            default: r_alu_op = ALU_ADD;
        endcase
    end

    // loads and stores fall through to add for the address
    always_comb begin
        case (op)
            OP_SLTI: i_alu_op = ALU_SLT;
            OP_ANDI: i_alu_op = ALU_AND;
            OP_ORI:  i_alu_op = ALU_OR;
            OP_XORI: i_alu_op = ALU_XOR;
            OP_LUI:  i_alu_op = ALU_LUI;
            default: i_alu_op = ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        state_next  = state;
        case (state)
            S_FETCH: begin
                // pc + 4 goes through the alu while the word is read
                ctrl.mem_read  = started;
                ctrl.alu_src_b = 2'd1;
                if (started && !waitrequest) begin
                    ctrl.ir_write = 1'b1;
                    ctrl.pc_write = 1'b1;
                    state_next    = S_DECODE;
                end
            end
            S_DECODE: begin
                // operands latched, branch target parked in aluout
                ctrl.a_write      = 1'b1;
                ctrl.b_write      = 1'b1;
                ctrl.alu_src_b    = 2'd3;
                ctrl.aluout_write = 1'b1;
                state_next        = S_EXEC;
            end
            S_EXEC: begin
                ctrl.alu_src_a = 1'b1;
                if (is_jr) begin
                    // rt is r0 for jr, so a + b is just a
                    if (halt) begin
                        state_next = S_HALTED;
                    end else begin
                        ctrl.pc_write = 1'b1;
                        state_next    = S_FETCH;
                    end
                end else if (is_rtype) begin
                    ctrl.alu_op       = r_alu_op;
                    ctrl.aluout_write = 1'b1;
                    state_next        = S_WB;
                end else if (is_branch) begin
                    ctrl.alu_op   = ALU_SUB;
                    ctrl.pc_src   = 2'd1;
                    ctrl.pc_write = zero ^ (op == OP_BNE);
                    state_next    = S_FETCH;
                end else if (is_jump) begin
                    ctrl.pc_src   = 2'd2;
                    ctrl.pc_write = 1'b1;
                    state_next    = S_FETCH;
                end else if (is_ialu || is_load || is_store) begin
                    ctrl.alu_src_b    = 2'd2;
                    ctrl.alu_op       = i_alu_op;
                    ctrl.imm_zero_ext = (op == OP_ANDI) || (op == OP_ORI) ||
                                        (op == OP_XORI) || (op == OP_LUI);
                    ctrl.aluout_write = 1'b1;
                    state_next        = (is_load || is_store) ? S_MEM : S_WB;
                end else begin
                    // unknown opcode is skipped
                    state_next = S_FETCH;
                end
            end
            S_MEM: begin
                ctrl.addr_from_aluout = 1'b1;
                if (is_load) begin
                    ctrl.mem_read = 1'b1;
                    if (!waitrequest) begin
                        ctrl.mdr_write = 1'b1;
                        state_next     = S_WB;
                    end
                end else begin
                    ctrl.mem_write = 1'b1;
                    if (!waitrequest) begin
                        state_next = S_FETCH;
                    end
                end
            end
            S_WB: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = is_rtype;
                ctrl.mem_to_reg = is_load;
                state_next      = S_FETCH;
            end
            S_HALTED: begin
                state_next = S_HALTED;
            end
            default: begin
                state_next = S_FETCH;
            end
        endcase
    end

    // started stays low through reset and the cycle after it, so the bus starts idle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= S_FETCH;
            started <= 1'b0;
        end else begin
            state   <= state_next;
            started <= 1'b1;
        end
    end

    assign active = (state != S_HALTED);

    assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.mem_read && ctrl.mem_write));

    // a stalled transfer keeps its strobes until waitrequest drops
    assert property (@(posedge clk) disable iff (!rst_n)
        ((ctrl.mem_read || ctrl.mem_write) && waitrequest)
        |=> $stable({ctrl.mem_read, ctrl.mem_write}));

    // halted is sticky and the bus stays idle
    assert property (@(posedge clk) disable iff (!rst_n)
        !active |=> (state == S_HALTED) && !active && !ctrl.mem_read && !ctrl.mem_write);

endmodule

//--- mips_cpu_bus.sv
`timescale 1ns/10ps

module mips_cpu_bus (
    input  logic        clk,
    input  logic        rst_n,
    output logic        active,
    output logic [31:0] register_v0,

    // avalon master, word accesses only
    output logic [31:0] address,
    output logic        write,
    output logic        read,
    input  logic        waitrequest,
    output logic [31:0] writedata,
    input  logic [31:0] readdata
);
    import mips_pkg::*;

    ctrl_t  ctrl;
    instr_t ir;
    logic   zero;
    logic   halt;

    mips_control ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .waitrequest (waitrequest),
        .ir          (ir),
        .zero        (zero),
        .halt        (halt),
        .ctrl        (ctrl),
        .active      (active)
    );

    mips_datapath dp_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .readdata    (readdata),
        .address     (address),
        .writedata   (writedata),
        .ir          (ir),
        .zero        (zero),
        .halt        (halt),
        .register_v0 (register_v0)
    );

    // bus strobes come straight from the control word
    assign read  = ctrl.mem_read;
    assign write = ctrl.mem_write;

endmodule

//--- mips_cpu_bus_tb.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module mips_cpu_bus_tb;
    import mips_pkg::*;

    localparam int          SEED           = 933;
    localparam int          STALL_DIV      = 3;
    localparam int          STALL_ALLOW    = 2;
    localparam int          RESET_CYCLES   = 8;
    localparam int          TAIL_CYCLES    = 20;
    localparam int          TIMEOUT_MARGIN = 4;
    localparam int          STEP_LIMIT     = 10000;
    localparam logic [31:0] DATA_BASE      = 32'h0000_1000;
    localparam int          DATA_WORDS     = 64;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [31:0] readdata;

    logic [31:0] prog [$];
    logic [31:0] init_mem [bit [31:0]];
    logic [31:0] model_mem [bit [31:0]];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    logic [31:0] exp_v0;
    logic [31:0] prev_addr;
    logic        prev_read;
    logic        prev_write;
    logic        req_stalled = 1'b0;
    int          errors = 0;
    int          stall_fetch = 0;
    int          stall_data = 0;
    int          cycle_count = 0;
    int          timeout_limit = 0;
    int          n_steps;

    always #5 clk = ~clk;

    mips_cpu_bus mips_cpu_bus_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .readdata    (readdata)
    );

    mips_tb_memory #(
        .STALL_DIV (STALL_DIV),
        .SEED      (SEED)
    ) mem_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sh,
                                           input funct_t fn);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_type(input opcode_t op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // target given as a word index into the program
    function automatic logic [31:0] j_type(input int index);
        logic [31:0] tgt;
        tgt = `MIPS_RESET_VECTOR + 4 * index;
        return {OP_J, tgt[27:2]};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9E37_79B9);
    endfunction

    task automatic build_program();
        prog.push_back(i_type(OP_ADDIU, 0, 8, 16'h1000));
        prog.push_back(i_type(OP_LW, 8, 9, 16'h0000));
        prog.push_back(i_type(OP_LW, 8, 10, 16'h0004));
        prog.push_back(i_type(OP_ADDIU, 0, 11, 16'hFFFB));
        prog.push_back(i_type(OP_ADDIU, 0, 12, 16'h0007));
        // -5 against 7, signed and unsigned
        prog.push_back(r_type(11, 12, 13, 0, F_SLT));
        prog.push_back(r_type(11, 12, 14, 0, F_SLTU));
        prog.push_back(i_type(OP_SLTI, 11, 15, 16'hFFFE));
        prog.push_back(i_type(OP_LUI, 0, 16, 16'h8000));
        prog.push_back(i_type(OP_ORI, 16, 16, 16'h1234));
        prog.push_back(i_type(OP_XORI, 16, 17, 16'hFFFF));
        prog.push_back(i_type(OP_ANDI, 9, 18, 16'h0FF0));
        prog.push_back(r_type(9, 10, 19, 0, F_ADDU));
        prog.push_back(r_type(9, 10, 20, 0, F_SUBU));
        prog.push_back(r_type(9, 10, 21, 0, F_AND));
        prog.push_back(r_type(21, 12, 22, 0, F_OR));
        prog.push_back(r_type(19, 22, 23, 0, F_XOR));
        prog.push_back(r_type(0, 16, 24, 3, F_SLL));
        prog.push_back(r_type(0, 16, 25, 7, F_SRL));
        prog.push_back(i_type(OP_SW, 8, 19, 16'h0008));
        prog.push_back(i_type(OP_SW, 8, 23, 16'h000C));
        // beq not taken, then bne and beq taken over one word each
        prog.push_back(i_type(OP_BEQ, 13, 14, 16'h0001));
        prog.push_back(i_type(OP_SW, 8, 24, 16'h0010));
        prog.push_back(i_type(OP_BNE, 13, 14, 16'h0001));
        prog.push_back(i_type(OP_SW, 8, 0, 16'h0014));
        prog.push_back(i_type(OP_BEQ, 14, 0, 16'h0001));
        prog.push_back(i_type(OP_ADDIU, 0, 2, 16'h0064));
        prog.push_back(i_type(OP_BNE, 13, 15, 16'h0001));
        prog.push_back(i_type(OP_SW, 8, 25, 16'h0014));
        prog.push_back(i_type(OP_LW, 8, 26, 16'h0008));
        prog.push_back(r_type(26, 17, 2, 0, F_ADDU));
        prog.push_back(r_type(2, 18, 2, 0, F_XOR));
        prog.push_back(j_type(34));
        prog.push_back(i_type(OP_SW, 8, 0, 16'h0018));
        prog.push_back(r_type(12, 11, 27, 0, F_SLTU));
        prog.push_back(r_type(2, 27, 2, 0, F_ADDU));
        // three pass loop closed by a backward bne
        prog.push_back(i_type(OP_ADDIU, 0, 4, 16'h0003));
        prog.push_back(r_type(2, 4, 2, 0, F_ADDU));
        prog.push_back(i_type(OP_ADDIU, 4, 4, 16'hFFFF));
        prog.push_back(i_type(OP_BNE, 4, 0, 16'hFFFD));
        prog.push_back(i_type(OP_LUI, 0, 28, 16'hBFC0));
        prog.push_back(i_type(OP_ORI, 28, 28, 16'h00B0));
        prog.push_back(r_type(28, 0, 0, 0, F_JR));
        prog.push_back(i_type(OP_SW, 8, 0, 16'h001C));
        prog.push_back(i_type(OP_SW, 8, 2, 16'h0018));
        // final v0 comes back through a load
        prog.push_back(i_type(OP_LW, 8, 2, 16'h0014));
        prog.push_back(r_type(0, 0, 0, 0, F_JR));
    endtask

    task automatic load_memory();
        logic [31:0] a;
        for (int k = 0; k < prog.size(); k++) begin
            a = `MIPS_RESET_VECTOR + 4 * k;
            mem_i.load_word(a, prog[k]);
            init_mem[a] = prog[k];
        end
        for (int k = 0; k < DATA_WORDS; k++) begin
            a = DATA_BASE + 4 * k;
            mem_i.load_word(a, fill_word(a));
            init_mem[a] = fill_word(a);
        end
    endtask

    // instruction set model, no delay slots, stops on jr to the halt address
    function automatic int run_model(output logic [31:0] v0);
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_s;
        logic [31:0] imm_z;
        logic [31:0] ea;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic        done;
        int          steps;
        for (int k = 0; k < 32; k++) begin
            regs[k] = 32'h0;
        end
        model_mem = init_mem;
        pc = `MIPS_RESET_VECTOR;
        done = 1'b0;
        steps = 0;
        while (!done && steps < STEP_LIMIT) begin
            w = model_mem.exists(pc) ? model_mem[pc] : 32'h0;
            a = regs[w[25:21]];
            b = regs[w[20:16]];
            rt = w[20:16];
            rd = w[15:11];
            sh = w[10:6];
            imm_s = {{16{w[15]}}, w[15:0]};
            imm_z = {16'h0000, w[15:0]};
            ea = a + imm_s;
            pc_next = pc + 4;
            steps++;
            case (w[31:26])
                OP_SPECIAL: begin
                    case (w[5:0])
                        F_ADDU: regs[rd] = a + b;
                        F_SUBU: regs[rd] = a - b;
                        F_AND:  regs[rd] = a & b;
                        F_OR:   regs[rd] = a | b;
                        F_XOR:  regs[rd] = a ^ b;
                        F_SLT:  regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        F_SLTU: regs[rd] = (a < b) ? 32'd1 : 32'd0;
                        F_SLL:  regs[rd] = b << sh;
                        F_SRL:  regs[rd] = b >> sh;
                        F_JR: begin
                            if (a == `MIPS_HALT_ADDR) begin
                                done = 1'b1;
                            end else begin
                                pc_next = a;
                            end
                        end
                        default: ;
                    endcase
                end
                OP_ADDIU: regs[rt] = a + imm_s;
                OP_SLTI:  regs[rt] = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
                OP_ANDI:  regs[rt] = a & imm_z;
                OP_ORI:   regs[rt] = a | imm_z;
                OP_XORI:  regs[rt] = a ^ imm_z;
                OP_LUI:   regs[rt] = {w[15:0], 16'h0000};
                OP_LW:    regs[rt] = model_mem.exists(ea) ? model_mem[ea] : 32'h0;
                OP_SW: begin
                    model_mem[ea] = b;
                    exp_st_addr.push_back(ea);
                    exp_st_data.push_back(b);
                end
                OP_BEQ: begin
                    if (a == b) begin
                        pc_next = pc + 4 + (imm_s << 2);
                    end
                end
                OP_BNE: begin
                    if (a != b) begin
                        pc_next = pc + 4 + (imm_s << 2);
                    end
                end
                OP_J:     pc_next = {pc_next[31:28], w[25:0], 2'b00};
                default: ;
            endcase
            regs[0] = 32'h0;
            pc = pc_next;
        end
        v0 = regs[2];
        return steps;
    endfunction

    task automatic compare_results();
        int n_exp;
        int n_got;
        n_exp = exp_st_addr.size();
        n_got = mem_i.wr_addr_q.size();
        if (register_v0 !== exp_v0) begin
            $display("Mismatch at %0t: register_v0 is %h, expected %h", $time, register_v0,
                     exp_v0);
            errors++;
        end
        if (n_got != n_exp) begin
            $display("Mismatch at %0t: %0d stores logged, expected %0d", $time, n_got, n_exp);
            errors++;
        end
        for (int k = 0; k < n_exp && k < n_got; k++) begin
            if (mem_i.wr_addr_q[k] !== exp_st_addr[k] ||
                mem_i.wr_data_q[k] !== exp_st_data[k]) begin
                $display("Mismatch at %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                         k, mem_i.wr_data_q[k], mem_i.wr_addr_q[k], exp_st_data[k],
                         exp_st_addr[k]);
                errors++;
            end
        end
        if (stall_fetch == 0 || stall_data == 0) begin
            $display("Error: waitrequest never stalled both a fetch and a data access");
            errors++;
        end
    endtask

    // a stalled request must hold its address and strobes
    always @(posedge clk) begin
        if (rst_n === 1'b1) begin
            if (req_stalled && (read !== prev_read || write !== prev_write ||
                                address !== prev_addr)) begin
                $display("Error at %0t: bus request changed while waitrequest was high",
                         $time);
                errors++;
            end
            if ((read === 1'b1 || write === 1'b1) && waitrequest === 1'b1) begin
                if (write === 1'b1 || address < `MIPS_RESET_VECTOR) begin
                    stall_data++;
                end else begin
                    stall_fetch++;
                end
            end
        end
        req_stalled = (read === 1'b1 || write === 1'b1) && waitrequest === 1'b1;
        prev_read = read;
        prev_write = write;
        prev_addr = address;
    end

    always @(posedge clk) begin
        if (rst_n === 1'b1 && active === 1'b1) begin
            cycle_count++;
            if (cycle_count > timeout_limit) begin
                $display("Error at %0t: CPU did not halt within %0d cycles", $time,
                         timeout_limit);
                $display("TEST FAILED");
                $finish;
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        build_program();
        load_memory();
        n_steps = run_model(exp_v0);
        timeout_limit = TIMEOUT_MARGIN * (n_steps * (5 + STALL_ALLOW) + RESET_CYCLES);

        // state is unknown before the first edge
        for (int k = 0; k < RESET_CYCLES; k++) begin
            @(posedge clk);
            if (k > 0 && (read !== 1'b0 || write !== 1'b0 || active !== 1'b1)) begin
                $display("Error at %0t: bus request or inactive core during reset", $time);
                errors++;
            end
        end
        #1 rst_n = 1'b1;

        @(posedge clk);
        if (read !== 1'b0 || write !== 1'b0 || active !== 1'b1) begin
            $display("Error at %0t: bus not idle in the first cycle after reset", $time);
            errors++;
        end

        while (read !== 1'b1 && active === 1'b1) begin
            @(posedge clk);
        end
        if (write !== 1'b0 || read !== 1'b1) begin
            $display("Error at %0t: no clean fetch request after reset", $time);
            errors++;
        end
        if (address !== `MIPS_RESET_VECTOR) begin
            $display("Mismatch at %0t: first fetch from %h, expected %h", $time, address,
                     `MIPS_RESET_VECTOR);
            errors++;
        end

        while (active !== 1'b0) begin
            @(posedge clk);
        end

        for (int k = 0; k < TAIL_CYCLES; k++) begin
            @(posedge clk);
            if (read !== 1'b0 || write !== 1'b0 || active !== 1'b0) begin
                $display("Error at %0t: bus activity after the core halted", $time);
                errors++;
            end
        end

        compare_results();
        $display("errors: %0d, stores: %0d, model steps: %0d, stalls fetch/data: %0d/%0d",
                 errors, exp_st_addr.size(), n_steps, stall_fetch, stall_data);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- mips_datapath.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module mips_datapath (
    input  logic             clk,
    input  logic             rst_n,
    input  mips_pkg::ctrl_t  ctrl,
    input  logic [31:0]      readdata,
    output logic [31:0]      address,
    output logic [31:0]      writedata,
    output mips_pkg::instr_t ir,
    output logic             zero,
    output logic             halt,
    output logic [31:0]      register_v0
);
    import mips_pkg::*;

    logic [31:0]             pc;
    logic [31:0]             mdr;
    logic [31:0]             a_reg;
    logic [31:0]             b_reg;
    logic [31:0]             aluout;
    logic [31:0]             rd1;
    logic [31:0]             rd2;
    logic [31:0]             imm_ext;
    logic [31:0]             alu_a;
    logic [31:0]             alu_b;
    logic [31:0]             alu_result;
    logic [31:0]             jump_target;
    logic [31:0]             pc_next;
    logic [`MIPS_REG_AW-1:0] wa;
    logic [31:0]             wd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `MIPS_RESET_VECTOR;
            ir <= '0;
        end else begin
            if (ctrl.pc_write) begin
                pc <= pc_next;
            end
            if (ctrl.ir_write) begin
                ir <= readdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.mdr_write) begin
            mdr <= readdata;
        end
        if (ctrl.a_write) begin
            a_reg <= rd1;
        end
        if (ctrl.b_write) begin
            b_reg <= rd2;
        end
        if (ctrl.aluout_write) begin
            aluout <= alu_result;
        end
    end

    // rt is the target for i-type results and loads
    assign wa = ctrl.reg_dst ? ir.r.rd : ir.i.rt;
    assign wd = ctrl.mem_to_reg ? mdr : aluout;

    mips_regfile rf_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (ir.r.rs),
        .ra2   (ir.r.rt),
        .wa    (wa),
        .we    (ctrl.reg_write),
        .wd    (wd),
        .rd1   (rd1),
        .rd2   (rd2),
        .v0    (register_v0)
    );

    assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, ir.i.imm16}
                                       : {{16{ir.i.imm16[15]}}, ir.i.imm16};
    assign alu_a   = ctrl.alu_src_a ? a_reg : pc;

    always_comb begin
        case (ctrl.alu_src_b)
            2'd1:    alu_b = 32'd4;
            2'd2:    alu_b = imm_ext;
            2'd3:    alu_b = {imm_ext[29:0], 2'b00};
            default: alu_b = b_reg;
        endcase
    end

    mips_alu alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .shamt  (ir.r.shamt),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (zero)
    );

    // pc already points past the jump, so its top nibble is the region
    assign jump_target = {pc[31:28], ir.i.rs, ir.i.rt, ir.i.imm16, 2'b00};

    always_comb begin
        case (ctrl.pc_src)
            2'd1:    pc_next = aluout;
            2'd2:    pc_next = jump_target;
            default: pc_next = alu_result;
        endcase
    end

    assign address   = ctrl.addr_from_aluout ? aluout : pc;
    assign writedata = b_reg;
    assign halt      = (ir.r.opcode == OP_SPECIAL) && (ir.r.funct == F_JR) &&
                       (a_reg == `MIPS_HALT_ADDR);

    assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl.mem_read || ctrl.mem_write) |-> (address[1:0] == 2'b00));

endmodule

//--- mips_pkg.sv
package mips_pkg;

    // primary opcodes, special covers all r-type words
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_t;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2A,
        F_SLTU = 6'h2B
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_MEM,
        S_WB,
        S_HALTED
    } state_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_view_t;

    // jump target is rs, rt and imm16 read back to back
    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_t;

    typedef struct packed {
        logic       pc_write;
        logic       ir_write;
        logic       mdr_write;
        logic       a_write;
        logic       b_write;
        logic       aluout_write;
        logic       reg_write;
        // 0 pc, 1 register a
        logic       alu_src_a;
        // 0 register b, 1 constant 4, 2 immediate, 3 immediate times 4
        logic [1:0] alu_src_b;
        logic       reg_dst;
        logic       mem_to_reg;
        logic       addr_from_aluout;
        // 0 alu result, 1 aluout, 2 jump target
        logic [1:0] pc_src;
        alu_op_t    alu_op;
        logic       imm_zero_ext;
        logic       mem_read;
        logic       mem_write;
    } ctrl_t;

endpackage

//--- mips_regfile.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module mips_regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`MIPS_REG_AW-1:0] ra1,
    input  logic [`MIPS_REG_AW-1:0] ra2,
    input  logic [`MIPS_REG_AW-1:0] wa,
    input  logic                    we,
    input  logic [31:0]             wd,
    output logic [31:0]             rd1,
    output logic [31:0]             rd2,
    output logic [31:0]             v0
);
    logic [31:0] regs [`MIPS_NREGS];

    // r0 never takes a write, so it reads back as zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];
    assign v0  = regs[2];

endmodule

//--- mips_tb_memory.sv
`timescale 1ns/10ps

module mips_tb_memory #(
    parameter int STALL_DIV = 3,
    parameter int SEED      = 933
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic        waitrequest,
    output logic [31:0] readdata
);
    logic [31:0] mem [bit [31:0]];

    // completed writes in bus order
    logic [31:0] wr_addr_q [$];
    logic [31:0] wr_data_q [$];

    task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr] = data;
    endtask

    function automatic logic [31:0] lookup(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return 32'h0000_0000;
    endfunction

    initial begin
        waitrequest = 1'b0;
        readdata    = 32'h0000_0000;
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            // a write completes in a cycle where waitrequest was low
            if (rst_n === 1'b1 && write === 1'b1 && waitrequest === 1'b0) begin
                mem[address] = writedata;
                wr_addr_q.push_back(address);
                wr_data_q.push_back(writedata);
            end
            #1;
            if (read === 1'b1 || write === 1'b1) begin
                waitrequest = ($urandom % STALL_DIV) == 0;
            end else begin
                waitrequest = 1'b0;
            end
            readdata = (read === 1'b1) ? lookup(address) : 32'h0000_0000;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sim.f --top-module mips_cpu_bus_tb -o mips_sim

sim_output=$(./obj_dir/mips_sim)
echo "$sim_output"

if grep -qx "TEST PASSED" <<< "$sim_output"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1

//--- sim.f
+incdir+.
mips_pkg.sv
mips_alu.sv
mips_regfile.sv
mips_control.sv
mips_datapath.sv
mips_cpu_bus.sv
mips_tb_memory.sv
mips_cpu_bus_tb.sv
